// ==== common/axi_pkg.sv ====
package axi_pkg;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } resp_t;

    // write address
    typedef struct packed {
        logic [31:0] addr;
        logic [2:0]  prot;
    } aw_t;

    // write data, one strobe bit per byte lane
    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;
    } w_t;

    typedef struct packed {
        resp_t resp;
    } b_t;

    // read address
    typedef struct packed {
        logic [31:0] addr;
        logic [2:0]  prot;
    } ar_t;

    typedef struct packed {
        logic [31:0] data;
        resp_t       resp;
    } r_t;

endpackage

// ==== common/core_pkg.sv ====
package core_pkg;

    // memory map
    localparam logic [31:0] CODE_BASE = 32'h0000_1000;
    localparam logic [31:0] CODE_SIZE = 32'h0000_0400;
    localparam logic [31:0] DATA_BASE = 32'h0000_2000;
    localparam logic [31:0] DATA_SIZE = 32'h0000_0400;
    localparam logic [31:0] MMIO_BASE = 32'h8000_0000; // everything above is mmio

    // ram depths in 32-bit words
    localparam int CODE_WORDS = 256;
    localparam int DATA_WORDS = 256;

    // mmio register offsets
    localparam logic [31:0] MMIO_OUT     = 32'h0;
    localparam logic [31:0] MMIO_IN      = 32'h4;
    localparam logic [31:0] MMIO_SCRATCH = 32'h8;

    localparam int GPIO_WIDTH = 8;

endpackage

// ==== bus_router/bus_router.sv ====
module bus_router (
    input  logic         aclk,
    input  logic         rst,
    // master side
    input  logic         cache_awvalid,
    output logic         cache_awready,
    input  axi_pkg::aw_t cache_aw,
    input  logic         cache_wvalid,
    output logic         cache_wready,
    input  axi_pkg::w_t  cache_w,
    output logic         cache_bvalid,
    input  logic         cache_bready,
    output axi_pkg::b_t  cache_b,
    input  logic         cache_arvalid,
    output logic         cache_arready,
    input  axi_pkg::ar_t cache_ar,
    output logic         cache_rvalid,
    input  logic         cache_rready,
    output axi_pkg::r_t  cache_r,
    // code ram, no read channels
    output logic         code_awvalid,
    input  logic         code_awready,
    output axi_pkg::aw_t code_aw,
    output logic         code_wvalid,
    input  logic         code_wready,
    output axi_pkg::w_t  code_w,
    input  logic         code_bvalid,
    output logic         code_bready,
    input  axi_pkg::b_t  code_b,
    // data ram
    output logic         data_awvalid,
    input  logic         data_awready,
    output axi_pkg::aw_t data_aw,
    output logic         data_wvalid,
    input  logic         data_wready,
    output axi_pkg::w_t  data_w,
    input  logic         data_bvalid,
    output logic         data_bready,
    input  axi_pkg::b_t  data_b,
    output logic         data_arvalid,
    input  logic         data_arready,
    output axi_pkg::ar_t data_ar,
    input  logic         data_rvalid,
    output logic         data_rready,
    input  axi_pkg::r_t  data_r,
    // mmio registers
    output logic         mmio_awvalid,
    input  logic         mmio_awready,
    output axi_pkg::aw_t mmio_aw,
    output logic         mmio_wvalid,
    input  logic         mmio_wready,
    output axi_pkg::w_t  mmio_w,
    input  logic         mmio_bvalid,
    output logic         mmio_bready,
    input  axi_pkg::b_t  mmio_b,
    output logic         mmio_arvalid,
    input  logic         mmio_arready,
    output axi_pkg::ar_t mmio_ar,
    input  logic         mmio_rvalid,
    output logic         mmio_rready,
    input  axi_pkg::r_t  mmio_r
);

    typedef enum logic [1:0] {NONE, CODE, DATA, MMIO} target_t;

    target_t wr_sel; // live decode of awaddr
    target_t rd_sel;
    target_t wr_tgt; // held until the response transfer
    target_t rd_tgt;
    logic    wr_busy;
    logic    rd_busy;

    function automatic target_t decode(input logic [31:0] addr);
        if (addr >= core_pkg::CODE_BASE && addr < core_pkg::CODE_BASE + core_pkg::CODE_SIZE)
            return CODE;
        else if (addr >= core_pkg::DATA_BASE && addr < core_pkg::DATA_BASE + core_pkg::DATA_SIZE)
            return DATA;
        else if (addr >= core_pkg::MMIO_BASE)
            return MMIO;
        else
            return NONE;
    endfunction

    assign wr_sel = decode(cache_aw.addr);
    assign rd_sel = decode(cache_ar.addr);

    // forwarded addresses are region relative
    always_comb begin
        code_aw      = cache_aw;
        code_aw.addr = cache_aw.addr - core_pkg::CODE_BASE;
        data_aw      = cache_aw;
        data_aw.addr = cache_aw.addr - core_pkg::DATA_BASE;
        mmio_aw      = cache_aw;
        mmio_aw.addr = cache_aw.addr - core_pkg::MMIO_BASE;
        data_ar      = cache_ar;
        data_ar.addr = cache_ar.addr - core_pkg::DATA_BASE;
        mmio_ar      = cache_ar;
        mmio_ar.addr = cache_ar.addr - core_pkg::MMIO_BASE;
    end

    assign code_w = cache_w;
    assign data_w = cache_w;
    assign mmio_w = cache_w;

    assign code_awvalid = !wr_busy && wr_sel == CODE && cache_awvalid;
    assign code_wvalid  = !wr_busy && wr_sel == CODE && cache_wvalid;
    assign data_awvalid = !wr_busy && wr_sel == DATA && cache_awvalid;
    assign data_wvalid  = !wr_busy && wr_sel == DATA && cache_wvalid;
    assign mmio_awvalid = !wr_busy && wr_sel == MMIO && cache_awvalid;
    assign mmio_wvalid  = !wr_busy && wr_sel == MMIO && cache_wvalid;
    assign data_arvalid = !rd_busy && rd_sel == DATA && cache_arvalid;
    assign mmio_arvalid = !rd_busy && rd_sel == MMIO && cache_arvalid;

    always_comb begin
        cache_awready = 1'b0;
        cache_wready  = 1'b0;
        if (!wr_busy) begin
            unique case (wr_sel)
                CODE: begin
                    cache_awready = code_awready;
                    cache_wready  = code_wready;
                end
                DATA: begin
                    cache_awready = data_awready;
                    cache_wready  = data_wready;
                end
                MMIO: begin
                    cache_awready = mmio_awready;
                    cache_wready  = mmio_wready;
                end
                default: begin // unmapped, answered here
                    cache_awready = cache_awvalid && cache_wvalid;
                    cache_wready  = cache_awvalid && cache_wvalid;
                end
            endcase
        end
    end

    always_comb begin
        cache_bvalid = 1'b0;
        cache_b      = '{resp: axi_pkg::DECERR};
        if (wr_busy) begin
            unique case (wr_tgt)
                CODE: begin
                    cache_bvalid = code_bvalid;
                    cache_b      = code_b;
                end
                DATA: begin
                    cache_bvalid = data_bvalid;
                    cache_b      = data_b;
                end
                MMIO: begin
                    cache_bvalid = mmio_bvalid;
                    cache_b      = mmio_b;
                end
                default: cache_bvalid = 1'b1;
            endcase
        end
    end

    assign code_bready = wr_busy && wr_tgt == CODE && cache_bready;
    assign data_bready = wr_busy && wr_tgt == DATA && cache_bready;
    assign mmio_bready = wr_busy && wr_tgt == MMIO && cache_bready;

    always_comb begin
        cache_arready = 1'b0;
        if (!rd_busy) begin
            unique case (rd_sel)
                DATA:    cache_arready = data_arready;
                MMIO:    cache_arready = mmio_arready;
                default: cache_arready = cache_arvalid; // code has no bus read path
            endcase
        end
    end

    always_comb begin
        cache_rvalid = 1'b0;
        cache_r      = '{data: '0, resp: axi_pkg::DECERR};
        if (rd_busy) begin
            unique case (rd_tgt)
                DATA: begin
                    cache_rvalid = data_rvalid;
                    cache_r      = data_r;
                end
                MMIO: begin
                    cache_rvalid = mmio_rvalid;
                    cache_r      = mmio_r;
                end
                default: cache_rvalid = 1'b1;
            endcase
        end
    end

    assign data_rready = rd_busy && rd_tgt == DATA && cache_rready;
    assign mmio_rready = rd_busy && rd_tgt == MMIO && cache_rready;

    always_ff @(posedge aclk) begin
        if (rst) begin
            wr_busy <= 1'b0;
            wr_tgt  <= NONE;
            rd_busy <= 1'b0;
            rd_tgt  <= NONE;
        end else begin
            if (cache_awvalid && cache_awready) begin
                wr_busy <= 1'b1;
                wr_tgt  <= wr_sel;
            end else if (cache_bvalid && cache_bready) begin
                wr_busy <= 1'b0;
            end
            if (cache_arvalid && cache_arready) begin
                rd_busy <= 1'b1;
                rd_tgt  <= rd_sel;
            end else if (cache_rvalid && cache_rready) begin
                rd_busy <= 1'b0;
            end
        end
    end

    // one downstream response pending per direction
    assert property (@(posedge aclk) disable iff (rst)
        $onehot0({code_bvalid, data_bvalid, mmio_bvalid}) &&
        $onehot0({data_rvalid, mmio_rvalid}));

    // response held under back-pressure
    assert property (@(posedge aclk) disable iff (rst)
        cache_bvalid && !cache_bready |=> cache_bvalid && $stable(cache_b));

endmodule

// ==== src/code_ram.sv ====
module code_ram #(
    parameter int DEPTH = core_pkg::CODE_WORDS
) (
    input  logic                     aclk,
    input  logic                     rst,
    input  logic                     awvalid,
    output logic                     awready,
    input  axi_pkg::aw_t             aw,
    input  logic                     wvalid,
    output logic                     wready,
    input  axi_pkg::w_t              w,
    output logic                     bvalid,
    input  logic                     bready,
    output axi_pkg::b_t              b,
    input  logic [$clog2(DEPTH)-1:0] fetch_addr,
    output logic [31:0]              fetch_data
);

    logic [31:0]              mem [DEPTH];
    logic [$clog2(DEPTH)-1:0] wr_idx;
    logic                     wr_fire;

    assign awready = awvalid && wvalid && !bvalid;
    assign wready  = awready;
    assign wr_fire = awvalid && awready;
    assign wr_idx  = aw.addr[$clog2(DEPTH)+1:2]; // word index
    assign b       = '{resp: axi_pkg::OKAY};

    always_ff @(posedge aclk) begin
        if (wr_fire) begin
            for (int i = 0; i < 4; i++) begin
                if (w.strb[i])
                    mem[wr_idx][8*i +: 8] <= w.data[8*i +: 8];
            end
        end
    end

    // fetch sees the old word on a same-cycle write
    always_ff @(posedge aclk) begin
        fetch_data <= mem[fetch_addr];
    end

    always_ff @(posedge aclk) begin
        if (rst)
            bvalid <= 1'b0;
        else if (wr_fire)
            bvalid <= 1'b1;
        else if (bready)
            bvalid <= 1'b0;
    end

    // one write in flight, the next waits for the b transfer
    assert property (@(posedge aclk) disable iff (rst)
        bvalid |-> !awvalid && !wvalid);

endmodule

// ==== src/data_ram.sv ====
module data_ram #(
    parameter int DEPTH = core_pkg::DATA_WORDS
) (
    input  logic         aclk,
    input  logic         rst,
    input  logic         awvalid,
    output logic         awready,
    input  axi_pkg::aw_t aw,
    input  logic         wvalid,
    output logic         wready,
    input  axi_pkg::w_t  w,
    output logic         bvalid,
    input  logic         bready,
    output axi_pkg::b_t  b,
    input  logic         arvalid,
    output logic         arready,
    input  axi_pkg::ar_t ar,
    output logic         rvalid,
    input  logic         rready,
    output axi_pkg::r_t  r
);

    logic [31:0]              mem [DEPTH];
    logic [31:0]              rdata_q;
    logic [$clog2(DEPTH)-1:0] wr_idx;
    logic [$clog2(DEPTH)-1:0] rd_idx;
    logic                     wr_fire;
    logic                     rd_fire;

    assign awready = awvalid && wvalid && !bvalid;
    assign wready  = awready;
    assign arready = arvalid && !rvalid;
    assign wr_fire = awvalid && awready;
    assign rd_fire = arvalid && arready;
    assign wr_idx  = aw.addr[$clog2(DEPTH)+1:2];
    assign rd_idx  = ar.addr[$clog2(DEPTH)+1:2];
    assign b       = '{resp: axi_pkg::OKAY};
    assign r       = '{data: rdata_q, resp: axi_pkg::OKAY};

    always_ff @(posedge aclk) begin
        if (wr_fire) begin
            for (int i = 0; i < 4; i++) begin
                if (w.strb[i])
                    mem[wr_idx][8*i +: 8] <= w.data[8*i +: 8];
            end
        end
        if (rd_fire)
            rdata_q <= mem[rd_idx];
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            bvalid <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            if (wr_fire)
                bvalid <= 1'b1;
            else if (bready)
                bvalid <= 1'b0;
            if (rd_fire)
                rvalid <= 1'b1;
            else if (rready)
                rvalid <= 1'b0;
        end
    end

endmodule

// ==== src/mmio_regs.sv ====
module mmio_regs (
    input  logic                           aclk,
    input  logic                           rst,
    input  logic                           awvalid,
    output logic                           awready,
    input  axi_pkg::aw_t                   aw,
    input  logic                           wvalid,
    output logic                           wready,
    input  axi_pkg::w_t                    w,
    output logic                           bvalid,
    input  logic                           bready,
    output axi_pkg::b_t                    b,
    input  logic                           arvalid,
    output logic                           arready,
    input  axi_pkg::ar_t                   ar,
    output logic                           rvalid,
    input  logic                           rready,
    output axi_pkg::r_t                    r,
    input  logic [core_pkg::GPIO_WIDTH-1:0] gpio_in,
    output logic [core_pkg::GPIO_WIDTH-1:0] gpio_out
);

    logic [31:0]                     out_q;
    logic [31:0]                     scratch_q;
    logic [core_pkg::GPIO_WIDTH-1:0] in_meta;
    logic [core_pkg::GPIO_WIDTH-1:0] in_sync;
    logic [31:0]                     rd_word;
    axi_pkg::resp_t                  rd_resp;
    logic                            wr_fire;
    logic                            rd_fire;

    function automatic logic [31:0] merge(input logic [31:0] old, input axi_pkg::w_t wd);
        logic [31:0] res;
        res = old;
        for (int i = 0; i < 4; i++) begin
            if (wd.strb[i])
                res[8*i +: 8] = wd.data[8*i +: 8];
        end
        return res;
    endfunction

    assign awready  = awvalid && wvalid && !bvalid;
    assign wready   = awready;
    assign arready  = arvalid && !rvalid;
    assign wr_fire  = awvalid && awready;
    assign rd_fire  = arvalid && arready;
    assign gpio_out = out_q[core_pkg::GPIO_WIDTH-1:0];

    always_comb begin
        rd_word = '0;
        rd_resp = axi_pkg::OKAY;
        case (ar.addr)
            core_pkg::MMIO_OUT:     rd_word = out_q;
            core_pkg::MMIO_IN:      rd_word[core_pkg::GPIO_WIDTH-1:0] = in_sync;
            core_pkg::MMIO_SCRATCH: rd_word = scratch_q;
            default:                rd_resp = axi_pkg::SLVERR;
        endcase
    end

    always_ff @(posedge aclk) begin
        in_meta <= gpio_in; // two-flop synchronizer
        in_sync <= in_meta;
        if (wr_fire) begin
            if (aw.addr == core_pkg::MMIO_OUT || aw.addr == core_pkg::MMIO_SCRATCH)
                b.resp <= axi_pkg::OKAY;
            else
                b.resp <= axi_pkg::SLVERR; // includes writes to the input register
        end
        if (rd_fire) begin
            r.data <= rd_word;
            r.resp <= rd_resp;
        end
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            out_q     <= '0;
            scratch_q <= '0;
            bvalid    <= 1'b0;
            rvalid    <= 1'b0;
        end else begin
            if (wr_fire) begin
                bvalid <= 1'b1;
                if (aw.addr == core_pkg::MMIO_OUT)
                    out_q <= merge(out_q, w);
                if (aw.addr == core_pkg::MMIO_SCRATCH)
                    scratch_q <= merge(scratch_q, w);
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            if (rd_fire)
                rvalid <= 1'b1;
            else if (rready)
                rvalid <= 1'b0;
        end
    end

endmodule

// ==== src/soc_mem_top.sv ====
module soc_mem_top (
    input  logic                                     aclk,
    input  logic                                     rst,
    input  logic                                     cache_awvalid,
    output logic                                     cache_awready,
    input  axi_pkg::aw_t                             cache_aw,
    input  logic                                     cache_wvalid,
    output logic                                     cache_wready,
    input  axi_pkg::w_t                              cache_w,
    output logic                                     cache_bvalid,
    input  logic                                     cache_bready,
    output axi_pkg::b_t                              cache_b,
    input  logic                                     cache_arvalid,
    output logic                                     cache_arready,
    input  axi_pkg::ar_t                             cache_ar,
    output logic                                     cache_rvalid,
    input  logic                                     cache_rready,
    output axi_pkg::r_t                              cache_r,
    input  logic [$clog2(core_pkg::CODE_WORDS)-1:0] fetch_addr,
    output logic [31:0]                              fetch_data,
    input  logic [core_pkg::GPIO_WIDTH-1:0]          gpio_in,
    output logic [core_pkg::GPIO_WIDTH-1:0]          gpio_out
);

    // code link
    logic         code_awvalid;
    logic         code_awready;
    logic         code_wvalid;
    logic         code_wready;
    logic         code_bvalid;
    logic         code_bready;
    axi_pkg::aw_t code_aw;
    axi_pkg::w_t  code_w;
    axi_pkg::b_t  code_b;

    // data link
    logic         data_awvalid;
    logic         data_awready;
    logic         data_wvalid;
    logic         data_wready;
    logic         data_bvalid;
    logic         data_bready;
    logic         data_arvalid;
    logic         data_arready;
    logic         data_rvalid;
    logic         data_rready;
    axi_pkg::aw_t data_aw;
    axi_pkg::w_t  data_w;
    axi_pkg::b_t  data_b;
    axi_pkg::ar_t data_ar;
    axi_pkg::r_t  data_r;

    // mmio link
    logic         mmio_awvalid;
    logic         mmio_awready;
    logic         mmio_wvalid;
    logic         mmio_wready;
    logic         mmio_bvalid;
    logic         mmio_bready;
    logic         mmio_arvalid;
    logic         mmio_arready;
    logic         mmio_rvalid;
    logic         mmio_rready;
    axi_pkg::aw_t mmio_aw;
    axi_pkg::w_t  mmio_w;
    axi_pkg::b_t  mmio_b;
    axi_pkg::ar_t mmio_ar;
    axi_pkg::r_t  mmio_r;

    // router port names match the link wires
    bus_router u_router (.*);

    code_ram u_code_ram (
        .aclk(aclk), .rst(rst),
        .awvalid(code_awvalid), .awready(code_awready), .aw(code_aw),
        .wvalid(code_wvalid), .wready(code_wready), .w(code_w),
        .bvalid(code_bvalid), .bready(code_bready), .b(code_b),
        .fetch_addr(fetch_addr), .fetch_data(fetch_data)
    );

    data_ram u_data_ram (
        .aclk(aclk), .rst(rst),
        .awvalid(data_awvalid), .awready(data_awready), .aw(data_aw),
        .wvalid(data_wvalid), .wready(data_wready), .w(data_w),
        .bvalid(data_bvalid), .bready(data_bready), .b(data_b),
        .arvalid(data_arvalid), .arready(data_arready), .ar(data_ar),
        .rvalid(data_rvalid), .rready(data_rready), .r(data_r)
    );

    mmio_regs u_mmio (
        .aclk(aclk), .rst(rst),
        .awvalid(mmio_awvalid), .awready(mmio_awready), .aw(mmio_aw),
        .wvalid(mmio_wvalid), .wready(mmio_wready), .w(mmio_w),
        .bvalid(mmio_bvalid), .bready(mmio_bready), .b(mmio_b),
        .arvalid(mmio_arvalid), .arready(mmio_arready), .ar(mmio_ar),
        .rvalid(mmio_rvalid), .rready(mmio_rready), .r(mmio_r),
        .gpio_in(gpio_in), .gpio_out(gpio_out)
    );

endmodule

// ==== test/soc_mem_tasks.svh ====
// xorshift32 data source
function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
endfunction

task automatic step_to_drive();
    @(posedge aclk);
    #1;
endtask

task automatic compare_word(input string what, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
        errors++;
        $display("Fail %0t: %s gave %h, expected %h", $time, what, got, exp);
    end
endtask

task automatic expect_resp(input string what, input logic [1:0] got, input logic [1:0] exp);
    assert (got === exp) else begin
        errors++;
        $display("Fail %0t: %s answered resp %b, expected %b", $time, what, got, exp);
    end
endtask

// returns at the drive slot after the aw/w transfer, valids dropped
task automatic await_write_accept(input logic [31:0] addr);
    int n;
    n = 0;
    @(negedge aclk);
    while (!(cache_awready && cache_wready) && n < TIMEOUT_CYCLES) begin
        @(negedge aclk);
        n++;
    end
    if (!(cache_awready && cache_wready)) begin
        timeouts++;
        $display("timeout: write to address %h was never accepted", addr);
    end
    step_to_drive();
    cache_awvalid = 1'b0;
    cache_wvalid  = 1'b0;
endtask

task automatic await_bvalid(input logic [31:0] addr, output axi_pkg::resp_t resp);
    int n;
    n = 0;
    @(negedge aclk);
    while (!cache_bvalid && n < TIMEOUT_CYCLES) begin
        @(negedge aclk);
        n++;
    end
    if (!cache_bvalid) begin
        timeouts++;
        $display("timeout: no write response for address %h", addr);
    end
    resp = cache_b.resp;
endtask

task automatic bus_write(input logic [31:0] addr, input logic [31:0] data,
                         input logic [3:0] strb, output axi_pkg::resp_t resp);
    step_to_drive();
    cache_aw      = '{addr: addr, prot: 3'b000};
    cache_w       = '{data: data, strb: strb};
    cache_awvalid = 1'b1;
    cache_wvalid  = 1'b1;
    cache_bready  = 1'b1;
    await_write_accept(addr);
    await_bvalid(addr, resp);
    step_to_drive(); // b transfer on this edge
endtask

task automatic bus_read(input logic [31:0] addr, output logic [31:0] data,
                        output axi_pkg::resp_t resp);
    int n;
    step_to_drive();
    cache_ar      = '{addr: addr, prot: 3'b000};
    cache_arvalid = 1'b1;
    cache_rready  = 1'b1;
    n = 0;
    @(negedge aclk);
    while (!cache_arready && n < TIMEOUT_CYCLES) begin
        @(negedge aclk);
        n++;
    end
    if (!cache_arready) begin
        timeouts++;
        $display("timeout: read of address %h was never accepted", addr);
    end
    step_to_drive();
    cache_arvalid = 1'b0;
    n = 0;
    @(negedge aclk);
    while (!cache_rvalid && n < TIMEOUT_CYCLES) begin
        @(negedge aclk);
        n++;
    end
    if (!cache_rvalid) begin
        timeouts++;
        $display("timeout: no read data for address %h", addr);
    end
    data = cache_r.data;
    resp = cache_r.resp;
    step_to_drive();
endtask

task automatic write_expect(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, input axi_pkg::resp_t exp);
    axi_pkg::resp_t resp;
    bus_write(addr, data, strb, resp);
    expect_resp($sformatf("write to %h", addr), resp, exp);
endtask

task automatic read_expect(input logic [31:0] addr, input logic [31:0] exp_data,
                           input axi_pkg::resp_t exp, input string what);
    logic [31:0]    data;
    axi_pkg::resp_t resp;
    bus_read(addr, data, resp);
    expect_resp(what, resp, exp);
    compare_word(what, data, exp_data);
endtask

// fetch data is registered, valid one cycle after the index
task automatic fetch_word(input logic [FETCH_BITS-1:0] idx, output logic [31:0] data);
    step_to_drive();
    fetch_addr = idx;
    @(posedge aclk);
    @(negedge aclk);
    data = fetch_data;
endtask

task automatic reset_state_test();
    compare_word("gpio_out after reset", 32'(gpio_out), 32'h0);
    read_expect(core_pkg::MMIO_BASE + core_pkg::MMIO_SCRATCH, 32'h0, axi_pkg::OKAY,
                "scratch after reset");
endtask

task automatic data_ram_test();
    logic [31:0] addrs [4];
    logic [31:0] words [4];
    logic [31:0] fresh;
    addrs = '{core_pkg::DATA_BASE, core_pkg::DATA_BASE + 32'h10,
              core_pkg::DATA_BASE + 32'h200, core_pkg::DATA_BASE + 32'h3fc};
    foreach (addrs[i]) begin
        words[i] = next_rand();
        write_expect(addrs[i], words[i], 4'hf, axi_pkg::OKAY);
    end
    foreach (addrs[i])
        read_expect(addrs[i], words[i], axi_pkg::OKAY, "data ram word");
    fresh = next_rand();
    write_expect(addrs[1], fresh, 4'b0011, axi_pkg::OKAY);
    read_expect(addrs[1], {words[1][31:16], fresh[15:0]}, axi_pkg::OKAY,
                "data ram half word write");
endtask

task automatic code_ram_test();
    logic [31:0] addrs [4];
    logic [31:0] words [4];
    logic [31:0] offs;
    logic [31:0] got;
    addrs = '{core_pkg::CODE_BASE, core_pkg::CODE_BASE + 32'h4,
              core_pkg::CODE_BASE + 32'h100, core_pkg::CODE_BASE + 32'h3fc};
    foreach (addrs[i]) begin
        words[i] = next_rand();
        write_expect(addrs[i], words[i], 4'hf, axi_pkg::OKAY);
    end
    foreach (addrs[i]) begin
        offs = addrs[i] - core_pkg::CODE_BASE;
        fetch_word(offs[FETCH_BITS+1:2], got); // byte offset to word index
        compare_word($sformatf("fetch of index %0d", offs >> 2), got, words[i]);
    end
    read_expect(core_pkg::CODE_BASE + 32'h4, 32'h0, axi_pkg::DECERR, "bus read of code");
endtask

task automatic mmio_test();
    logic [31:0] val;
    logic [31:0] pins;
    val = next_rand();
    write_expect(core_pkg::MMIO_BASE + core_pkg::MMIO_OUT, val, 4'hf, axi_pkg::OKAY);
    compare_word("gpio_out", 32'(gpio_out), 32'(val[core_pkg::GPIO_WIDTH-1:0]));
    read_expect(core_pkg::MMIO_BASE + core_pkg::MMIO_OUT, val, axi_pkg::OKAY, "output reg");
    pins = next_rand();
    step_to_drive();
    gpio_in = pins[core_pkg::GPIO_WIDTH-1:0];
    repeat (4) @(posedge aclk); // let the synchronizer settle
    read_expect(core_pkg::MMIO_BASE + core_pkg::MMIO_IN, 32'(pins[core_pkg::GPIO_WIDTH-1:0]),
                axi_pkg::OKAY, "input reg");
    val = next_rand();
    write_expect(core_pkg::MMIO_BASE + core_pkg::MMIO_SCRATCH, val, 4'hf, axi_pkg::OKAY);
    read_expect(core_pkg::MMIO_BASE + core_pkg::MMIO_SCRATCH, val, axi_pkg::OKAY, "scratch");
    write_expect(core_pkg::MMIO_BASE + core_pkg::MMIO_IN, next_rand(), 4'hf, axi_pkg::SLVERR);
    write_expect(core_pkg::MMIO_BASE + 32'hc, next_rand(), 4'hf, axi_pkg::SLVERR);
    read_expect(core_pkg::MMIO_BASE + 32'hc, 32'h0, axi_pkg::SLVERR, "unknown mmio offset");
endtask

task automatic unmapped_test();
    logic [31:0] val;
    write_expect(32'h0000_0100, next_rand(), 4'hf, axi_pkg::DECERR);
    read_expect(32'h0000_0100, 32'h0, axi_pkg::DECERR, "read below code");
    write_expect(32'h0000_3000, next_rand(), 4'hf, axi_pkg::DECERR);
    read_expect(32'h0000_3000, 32'h0, axi_pkg::DECERR, "read above data");
    val = next_rand();
    write_expect(core_pkg::DATA_BASE + 32'h40, val, 4'hf, axi_pkg::OKAY);
    read_expect(core_pkg::DATA_BASE + 32'h40, val, axi_pkg::OKAY, "data after decode error");
endtask

task automatic backpressure_test();
    logic [31:0]    first;
    logic [31:0]    second;
    axi_pkg::resp_t held;
    axi_pkg::resp_t resp;
    first  = next_rand();
    second = next_rand();
    step_to_drive();
    cache_bready  = 1'b0;
    cache_aw      = '{addr: core_pkg::DATA_BASE + 32'h80, prot: 3'b000};
    cache_w       = '{data: first, strb: 4'hf};
    cache_awvalid = 1'b1;
    cache_wvalid  = 1'b1;
    await_write_accept(core_pkg::DATA_BASE + 32'h80);
    await_bvalid(core_pkg::DATA_BASE + 32'h80, held);
    expect_resp("first write", held, axi_pkg::OKAY);
    // second write waits behind the held response
    step_to_drive();
    cache_aw      = '{addr: core_pkg::DATA_BASE + 32'h84, prot: 3'b000};
    cache_w       = '{data: second, strb: 4'hf};
    cache_awvalid = 1'b1;
    cache_wvalid  = 1'b1;
    repeat (5) begin
        @(negedge aclk);
        assert (cache_bvalid && cache_b.resp === held && !cache_awready) else begin
            errors++;
            $display("Fail %0t: held write response changed or second write accepted early",
                     $time);
        end
    end
    step_to_drive();
    cache_bready = 1'b1;
    await_write_accept(core_pkg::DATA_BASE + 32'h84);
    await_bvalid(core_pkg::DATA_BASE + 32'h84, resp);
    expect_resp("second write", resp, axi_pkg::OKAY);
    step_to_drive();
    read_expect(core_pkg::DATA_BASE + 32'h80, first, axi_pkg::OKAY, "first held write");
    read_expect(core_pkg::DATA_BASE + 32'h84, second, axi_pkg::OKAY, "second held write");
endtask

// ==== test/tb_soc_mem.sv ====
module tb_soc_mem;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int TIMEOUT_CYCLES = 50; // per wait loop
    localparam int FETCH_BITS     = $clog2(core_pkg::CODE_WORDS);

    logic                            aclk;
    logic                            rst;
    logic                            cache_awvalid;
    logic                            cache_awready;
    axi_pkg::aw_t                    cache_aw;
    logic                            cache_wvalid;
    logic                            cache_wready;
    axi_pkg::w_t                     cache_w;
    logic                            cache_bvalid;
    logic                            cache_bready;
    axi_pkg::b_t                     cache_b;
    logic                            cache_arvalid;
    logic                            cache_arready;
    axi_pkg::ar_t                    cache_ar;
    logic                            cache_rvalid;
    logic                            cache_rready;
    axi_pkg::r_t                     cache_r;
    logic [FETCH_BITS-1:0]           fetch_addr;
    logic [31:0]                     fetch_data;
    logic [core_pkg::GPIO_WIDTH-1:0] gpio_in;
    logic [core_pkg::GPIO_WIDTH-1:0] gpio_out;

    int          errors;
    int          timeouts;
    logic [31:0] rng_state;

    soc_mem_top u_dut (.*);

    `include "soc_mem_tasks.svh"

    initial begin
        aclk = 1'b0;
        forever #10 aclk = ~aclk;
    end

    initial begin
        errors        = 0;
        timeouts      = 0;
        rng_state     = 32'hf99b6bf2;
        rst           = 1'b1;
        cache_awvalid = 1'b0;
        cache_aw      = '0;
        cache_wvalid  = 1'b0;
        cache_w       = '0;
        cache_bready  = 1'b0;
        cache_arvalid = 1'b0;
        cache_ar      = '0;
        cache_rready  = 1'b0;
        fetch_addr    = '0;
        gpio_in       = '0;
        repeat (4) @(posedge aclk);
        #1 rst = 1'b0;

        reset_state_test(); // must run first
        data_ram_test();
        code_ram_test();
        mmio_test();
        unmapped_test();
        backpressure_test();

        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+test
common/axi_pkg.sv
common/core_pkg.sv
bus_router/bus_router.sv
src/code_ram.sv
src/data_ram.sv
src/mmio_regs.sv
src/soc_mem_top.sv
test/tb_soc_mem.sv
